// File: source/audio_pkg.sv
package audio_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Sample format
    ////////////////////////////////////////////////////////////////////////////

    // Width of one audio sample for both sources and the mixed output
    parameter int SAMPLE_WIDTH = 16;

    // Two's complement sample as delivered by the PCM and FM channels
    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

    ////////////////////////////////////////////////////////////////////////////
    // Clamp limits
    ////////////////////////////////////////////////////////////////////////////

    // Full-scale positive used when a sum overflows upward
    parameter sample_t SAMPLE_MAX = 16'sh7FFF;

    // Full-scale negative used when a sum overflows downward
    parameter sample_t SAMPLE_MIN = 16'sh8000;

endpackage

// File: source/dac_pkg.sv
package dac_pkg;

    // PWM resolution unless the top level overrides it
    parameter int PWM_BITS_DEFAULT = 8;

    // Moves a signed sample into offset binary with silence at mid scale
    parameter logic [audio_pkg::SAMPLE_WIDTH-1:0] OFFSET = 16'h8000;

    // Signed sample to unsigned offset-binary value
    function automatic logic [audio_pkg::SAMPLE_WIDTH-1:0] offset_binary(
        audio_pkg::sample_t sample
    );
        return sample + OFFSET;     // Wraps, so only the MSB flips
    endfunction

    // Right shift that keeps the top PWM bits of an offset-binary sample
    function automatic int duty_shift(int pwm_bits);
        return audio_pkg::SAMPLE_WIDTH - pwm_bits;
    endfunction

endpackage

// File: source/sample_mixer.sv
`timescale 1ns/1ps

module sample_mixer (
    input  logic               clk,
    input  logic               reset,

    // Source samples for one channel
    input  audio_pkg::sample_t pcm,
    input  audio_pkg::sample_t fm,

    // Registered, clamped sum
    output audio_pkg::sample_t mixed
);

    localparam int MSB = audio_pkg::SAMPLE_WIDTH - 1;

    ////////////////////////////////////////////////////////////////////////////
    // Sum with one guard bit
    ////////////////////////////////////////////////////////////////////////////

    logic [MSB+1:0]     sum;        // One extra sign bit
    audio_pkg::sample_t clamped;

    // Both operands sign-extended by hand
    assign sum = {pcm[MSB], pcm} + {fm[MSB], fm};

    ////////////////////////////////////////////////////////////////////////////
    // Saturation
    ////////////////////////////////////////////////////////////////////////////

    // Top two bits differ only when the result left the 16-bit range
    always_comb begin
        case (sum[MSB+1:MSB])
            2'b01:   clamped = audio_pkg::SAMPLE_MAX;    // Positive overflow
            2'b10:   clamped = audio_pkg::SAMPLE_MIN;    // Negative overflow
            default: clamped = sum[MSB:0];
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////////////////////

    // One clock from input change to mixed
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mixed <= '0;                // Silence until the first sum
        end else begin
            mixed <= clamped;
        end
    end

endmodule

// File: source/pwm_dac.sv
`timescale 1ns/1ps

module pwm_dac #(
    parameter int PWM_BITS = dac_pkg::PWM_BITS_DEFAULT
) (
    input  logic               clk,
    input  logic               reset,

    // Mixed samples read only at the period wrap
    input  audio_pkg::sample_t left_sample,
    input  audio_pkg::sample_t right_sample,

    // Strobe at the start of each PWM period
    output logic               sample_request,

    // PWM audio outputs
    output logic               audio_left,
    output logic               audio_right
);

    localparam int SHIFT = dac_pkg::duty_shift(PWM_BITS);
    localparam int CHANNELS = 2;

    ////////////////////////////////////////////////////////////////////////////
    // Period counter
    ////////////////////////////////////////////////////////////////////////////

    logic [PWM_BITS-1:0] count;
    logic                wrap;

    // Start of a period where the duties are taken
    assign wrap = (count == '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count          <= '0;
            sample_request <= 1'b0;
        end else begin
            count          <= count + 1'b1;     // Wraps at 2**PWM_BITS
            sample_request <= wrap;             // Lines up with the count 0 output
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Per-channel duty and comparator
    ////////////////////////////////////////////////////////////////////////////

    audio_pkg::sample_t samples [CHANNELS];

    assign samples[0] = left_sample;
    assign samples[1] = right_sample;

    for (genvar ch = 0; ch < CHANNELS; ch++) begin : g_chan
        logic [audio_pkg::SAMPLE_WIDTH-1:0] scaled;
        logic [PWM_BITS-1:0]                duty;
        logic [PWM_BITS-1:0]                duty_next;
        logic                               pwm_q;

        // Offset binary, then keep the top PWM_BITS bits
        assign scaled = dac_pkg::offset_binary(samples[ch]) >> SHIFT;

        // New duty already applies to count 0 of its own period
        assign duty_next = wrap ? scaled[PWM_BITS-1:0] : duty;

        always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
                duty  <= '0;
                pwm_q <= 1'b0;
            end else begin
                duty  <= duty_next;
                pwm_q <= (count < duty_next);   // High for exactly duty cycles
            end
        end
    end

    assign audio_left  = g_chan[0].pwm_q;
    assign audio_right = g_chan[1].pwm_q;

endmodule

// File: source/audio_out.sv
`timescale 1ns/1ps

module audio_out #(
    parameter int PWM_BITS = dac_pkg::PWM_BITS_DEFAULT
) (
    input  logic               clk,
    input  logic               reset,

    // PCM channel
    input  audio_pkg::sample_t pcm_left,
    input  audio_pkg::sample_t pcm_right,

    // FM channel
    input  audio_pkg::sample_t fm_left,
    input  audio_pkg::sample_t fm_right,

    // PWM audio outputs
    output logic               audio_left,
    output logic               audio_right,

    // New sample taken by the DAC
    output logic               sample_request
);

    audio_pkg::sample_t mixed_left;
    audio_pkg::sample_t mixed_right;

    ////////////////////////////////////////////////////////////////////////////
    // Mixers, one per channel
    ////////////////////////////////////////////////////////////////////////////

    sample_mixer mixer_left (
        .clk   (clk),
        .reset (reset),
        .pcm   (pcm_left),
        .fm    (fm_left),
        .mixed (mixed_left)
    );

    sample_mixer mixer_right (
        .clk   (clk),
        .reset (reset),
        .pcm   (pcm_right),
        .fm    (fm_right),
        .mixed (mixed_right)
    );

    ////////////////////////////////////////////////////////////////////////////
    // PWM DAC
    ////////////////////////////////////////////////////////////////////////////

    // Reads the mixer levels once per period without back-pressure
    pwm_dac #(
        .PWM_BITS (PWM_BITS)
    ) dac (
        .clk            (clk),
        .reset          (reset),
        .left_sample    (mixed_left),
        .right_sample   (mixed_right),
        .sample_request (sample_request),
        .audio_left     (audio_left),
        .audio_right    (audio_right)
    );

endmodule

// File: test/audio_out_properties.sv
`timescale 1ns/1ps

module audio_out_properties #(
    parameter int PWM_BITS = dac_pkg::PWM_BITS_DEFAULT
) (
    input logic clk,
    input logic reset,
    input logic audio_left,
    input logic audio_right,
    input logic sample_request
);

    localparam int PERIOD = 1 << PWM_BITS;

    int   since_request;    // Cycles since the last strobe
    logic request_seen;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            since_request <= 0;
            request_seen  <= 1'b0;
        end else if (sample_request) begin
            since_request <= 1;
            request_seen  <= 1'b1;
        end else begin
            since_request <= since_request + 1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reset behavior
    ////////////////////////////////////////////////////////////////////////////

    reset_quiet: assert property (
        @(posedge clk) reset |-> !audio_left && !audio_right && !sample_request
    ) else $error("PWM outputs or strobe active while reset is held");

    // DAC asks for its first sample right after release
    first_request: assert property (
        @(posedge clk) $fell(reset) |=> sample_request
    ) else $error("no strobe one cycle after reset release");

    ////////////////////////////////////////////////////////////////////////////
    // Strobe shape and spacing
    ////////////////////////////////////////////////////////////////////////////

    request_single: assert property (
        @(posedge clk) disable iff (reset) sample_request |=> !sample_request
    ) else $error("sample_request high for two cycles");

    request_period: assert property (
        @(posedge clk) disable iff (reset)
            sample_request && request_seen |-> since_request == PERIOD
    ) else $error("sample_request spacing differs from one PWM period");

endmodule

bind audio_out audio_out_properties #(
    .PWM_BITS (PWM_BITS)
) props (
    .clk            (clk),
    .reset          (reset),
    .audio_left     (audio_left),
    .audio_right    (audio_right),
    .sample_request (sample_request)
);

// File: test/audio_out_tb.sv
`timescale 1ns/1ps

module audio_out_tb;

    localparam int PWM_BITS     = 8;
    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 16;
    localparam int PERIOD       = 1 << PWM_BITS;    // Clock cycles per PWM period
    localparam int SHIFT        = audio_pkg::SAMPLE_WIDTH - PWM_BITS;
    localparam int NUM_TESTS    = 23;               // Measured periods over all tests
    localparam int TIMEOUT_NS   = NUM_TESTS * 4 * PERIOD * CLK_PERIOD
                                + RESET_CYCLES * CLK_PERIOD;

    // Signed 16-bit range and the offset-binary shift
    localparam int FULL_POS     = 32767;
    localparam int FULL_NEG     = -32768;
    localparam int MID_SCALE    = 32768;

    logic               clk;
    logic               reset;
    audio_pkg::sample_t pcm_left;
    audio_pkg::sample_t pcm_right;
    audio_pkg::sample_t fm_left;
    audio_pkg::sample_t fm_right;
    logic               audio_left;
    logic               audio_right;
    logic               sample_request;

    logic [31:0]        lfsr;

    // Inputs applied part way through a measured period
    int                 staged_pcm_left;
    int                 staged_fm_left;
    int                 staged_pcm_right;
    int                 staged_fm_right;

    audio_out #(
        .PWM_BITS (PWM_BITS)
    ) uut (
        .clk            (clk),
        .reset          (reset),
        .pcm_left       (pcm_left),
        .pcm_right      (pcm_right),
        .fm_left        (fm_left),
        .fm_right       (fm_right),
        .audio_left     (audio_left),
        .audio_right    (audio_right),
        .sample_request (sample_request)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_next(logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;    // Taps 32, 22, 2, 1
        end else begin
            return state >> 1;
        end
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    // 15-bit signed value, so any two of them add without overflow
    task automatic draw_small_sample(output int value);
        logic [31:0]        bits;
        audio_pkg::sample_t sample;
        draw_bits(15, bits);
        sample = $signed({bits[14], bits[14:0]});
        value  = int'(sample);
    endtask

    // Clamp, shift to offset binary, keep the top PWM bits
    function automatic int expected_duty(int pcm, int fm);
        int sum;
        sum = pcm + fm;
        if (sum > FULL_POS) begin
            sum = FULL_POS;
        end else if (sum < FULL_NEG) begin
            sum = FULL_NEG;
        end
        return (sum + MID_SCALE) >> SHIFT;
    endfunction

    task automatic check_value(input string what, input int actual, input int expected);
        if (actual != expected) begin
            $display("ERROR at time %0t: %s is %0d, expected %0d",
                     $time, what, actual, expected);
            $display("Simulation failed");
            $fatal(1, "mismatch in %s", what);
        end
    endtask

    task automatic set_inputs(input int pl, input int fl, input int pr, input int fr);
        pcm_left  = audio_pkg::sample_t'(pl);
        fm_left   = audio_pkg::sample_t'(fl);
        pcm_right = audio_pkg::sample_t'(pr);
        fm_right  = audio_pkg::sample_t'(fr);
    endtask

    task automatic apply_inputs(input int pl, input int fl, input int pr, input int fr);
        @(negedge clk);
        set_inputs(pl, fl, pr, fr);
    endtask

    // Returns on the falling edge where the strobe is high
    task automatic wait_request();
        @(negedge clk);
        while (sample_request !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    // Starts on a request, ends on the next one; change_at 0 means no change
    task automatic measure_period(input int change_at, output int left_high,
                                  output int right_high);
        int cycles;
        left_high  = 0;
        right_high = 0;
        cycles     = 0;
        do begin
            left_high  += int'(audio_left);
            right_high += int'(audio_right);
            cycles++;
            if (cycles == change_at) begin
                set_inputs(staged_pcm_left, staged_fm_left,
                           staged_pcm_right, staged_fm_right);
            end
            @(negedge clk);
        end while (sample_request !== 1'b1);
        check_value("cycles between requests", cycles, PERIOD);
    endtask

    // Second request is the first period that surely sees the new inputs
    task automatic run_pair(input string label, input int pl, input int fl,
                            input int pr, input int fr,
                            output int left_high, output int right_high);
        apply_inputs(pl, fl, pr, fr);
        wait_request();
        wait_request();
        measure_period(0, left_high, right_high);
        check_value({label, " left duty"}, left_high, expected_duty(pl, fl));
        check_value({label, " right duty"}, right_high, expected_duty(pr, fr));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic apply_reset();
        reset = 1'b1;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_value("audio_left in reset", int'(audio_left), 0);
            check_value("audio_right in reset", int'(audio_right), 0);
            check_value("sample_request in reset", int'(sample_request), 0);
        end
        reset = 1'b0;
    endtask

    task automatic after_reset_check();
        int left_high;
        int right_high;
        @(negedge clk);
        check_value("first request", int'(sample_request), 1);
        measure_period(0, left_high, right_high);
        check_value("idle left duty", left_high, expected_duty(0, 0));
        check_value("idle right duty", right_high, expected_duty(0, 0));
    endtask

    task automatic in_range_sums();
        int pl;
        int fl;
        int pr;
        int fr;
        int left_high;
        int right_high;
        for (int i = 0; i < 16; i++) begin
            draw_small_sample(pl);
            draw_small_sample(fl);
            draw_small_sample(pr);
            draw_small_sample(fr);
            run_pair($sformatf("random pair %0d", i), pl, fl, pr, fr,
                     left_high, right_high);
        end
    endtask

    task automatic positive_saturation();
        int left_high;
        int right_high;
        run_pair("positive clamp", int'(audio_pkg::SAMPLE_MAX), 1000, 20000, 20000,
                 left_high, right_high);
        check_value("positive clamp left full scale", left_high, PERIOD - 1);
        check_value("positive clamp right full scale", right_high, PERIOD - 1);
    endtask

    task automatic negative_saturation();
        int left_high;
        int right_high;
        run_pair("negative clamp", int'(audio_pkg::SAMPLE_MIN), -1000, -20000, -20000,
                 left_high, right_high);
        check_value("negative clamp left silent", left_high, 0);
        check_value("negative clamp right silent", right_high, 0);
    endtask

    task automatic channel_independence();
        int left_high;
        int right_high;
        run_pair("split channels", 12000, 3000, -9000, -7000, left_high, right_high);
        run_pair("opposite clamps", int'(audio_pkg::SAMPLE_MAX), 5000,
                 int'(audio_pkg::SAMPLE_MIN), -5000, left_high, right_high);
    endtask

    task automatic request_spacing();
        int left_high;
        int right_high;
        apply_inputs(-20000, 5000, 7000, 8000);
        wait_request();
        wait_request();
        staged_pcm_left  = 25000;
        staged_fm_left   = -2000;
        staged_pcm_right = -30000;
        staged_fm_right  = 1000;
        measure_period(PERIOD / 2, left_high, right_high);  // Change mid period
        check_value("mid change left duty", left_high, expected_duty(-20000, 5000));
        check_value("mid change right duty", right_high, expected_duty(7000, 8000));
        measure_period(0, left_high, right_high);           // Picks up the change
        check_value("next period left duty", left_high, expected_duty(25000, -2000));
        check_value("next period right duty", right_high, expected_duty(-30000, 1000));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clk              = 1'b0;
        reset            = 1'b1;
        pcm_left         = '0;
        pcm_right        = '0;
        fm_left          = '0;
        fm_right         = '0;
        lfsr             = 32'hc562_dbeb;
        staged_pcm_left  = 0;
        staged_fm_left   = 0;
        staged_pcm_right = 0;
        staged_fm_right  = 0;

        apply_reset();
        after_reset_check();
        in_range_sums();
        positive_saturation();
        negative_saturation();
        channel_independence();
        request_spacing();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: sources.f
source/audio_pkg.sv
source/dac_pkg.sv
source/sample_mixer.sv
source/pwm_dac.sv
source/audio_out.sv
test/audio_out_properties.sv
test/audio_out_tb.sv

// File: Makefile
# Verilator build and run for the audio output path

VERILATOR := verilator
VFLAGS    := --binary --assert -j 0
TOP       := audio_out_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir
PASS_MSG  := Simulation completed successfully

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard source/*.sv) $(wildcard test/*.sv)

.PHONY: all compile run clean

all: run

# Build the simulation executable
compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Run and look for the pass message in the output
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
